// ==== uberclock.f ====
rtl/uberclock_pkg.sv
rtl/cap_if.sv
rtl/channel_gain.sv
rtl/sum_tree.sv
rtl/dac_output_select.sv
rtl/capture_buffer.sv
rtl/wb_capture_port.sv
rtl/uberclock.sv
test/uberclock_sva.sv
test/tb_uberclock.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
SIM_FLAGS = --binary -Wno-fatal
TOP       = tb_uberclock
FILELIST  = uberclock.f
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/tb_uberclock.sv ====
`timescale 1ns/1ns

module tb_uberclock;

    localparam int CAP_DEPTH = 64;
    localparam int NCH = uberclock_pkg::NUM_CH;

    logic                             sys_clk;
    logic                             rst;
    uberclock_pkg::sample_t [NCH-1:0] ch_y;
    logic [NCH-1:0][31:0]             gain;
    logic [2:0]                       final_shift;
    logic [11:0]                      adc0;
    logic [11:0]                      adc1;
    logic [3:0]                       dac1_sel;
    logic [3:0]                       dac2_sel;
    logic                             sample_ce;
    logic                             wb_cyc;
    logic                             wb_stb;
    logic                             wb_we;
    logic [12:0]                      wb_adr;
    logic [15:0]                      wb_dat;
    uberclock_pkg::dac_word_t         dac1_data;
    uberclock_pkg::dac_word_t         dac2_data;
    uberclock_pkg::dac_word_t         sum_out;
    logic [15:0]                      wb_rdat;
    logic                             wb_ack;

    integer            seed;
    int                n_checks;
    int                test_errs;
    int                total_errs;
    string             test_name;
    logic signed [15:0] cap_exp [CAP_DEPTH];

    uberclock #(.CAP_DEPTH(CAP_DEPTH)) i_uberclock (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .i_ch_y        (ch_y),
        .i_gain        (gain),
        .i_final_shift (final_shift),
        .i_adc0        (adc0),
        .i_adc1        (adc1),
        .i_dac1_sel    (dac1_sel),
        .i_dac2_sel    (dac2_sel),
        .i_sample_ce   (sample_ce),
        .i_wb_cyc      (wb_cyc),
        .i_wb_stb      (wb_stb),
        .i_wb_we       (wb_we),
        .i_wb_adr      (wb_adr),
        .i_wb_dat      (wb_dat),
        .o_dac1_data   (dac1_data),
        .o_dac2_data   (dac2_data),
        .o_sum_out     (sum_out),
        .o_wb_dat      (wb_rdat),
        .o_wb_ack      (wb_ack)
    );

    // 20 ns clock
    initial sys_clk = 1'b0;
    always #10 sys_clk = ~sys_clk;

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // sample times unsigned gain, arithmetic shift by 30, low 16 bits
    function automatic logic signed [15:0] model_gain(input logic signed [15:0] y,
                                                      input logic [31:0] g);
        longint prod;
        prod = longint'(y) * longint'({32'd0, g});
        return 16'(prod >>> 30);
    endfunction

    function automatic int model_sum();
        int s;
        s = 0;
        for (int i = 0; i < NCH; i++) begin
            s += int'(model_gain(ch_y[3'(i)], gain[3'(i)]));
        end
        return s;
    endfunction

    // top 14 of the 19 sum bits
    function automatic logic [13:0] sum_top(input int s);
        return s[18:5];
    endfunction

    function automatic logic [13:0] dac_expect(input logic [3:0] sel);
        logic signed [15:0] g;
        logic [13:0]        w;
        if (sel <= 4'd4) begin
            g = model_gain(ch_y[sel[2:0]], gain[sel[2:0]]);
            w = g[15:2];
        end else if (sel == 4'd11) begin
            w = {~adc0[11], adc0[10:0], 2'b00};
        end else if (sel == 4'd12) begin
            w = {~adc1[11], adc1[10:0], 2'b00};
        end else begin
            // unused codes fall through to the sum
            w = sum_top(model_sum());
        end
        return w + 14'd8192;
    endfunction

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    // inputs change 2 ns after the edge
    task automatic step(input int n);
        repeat (n) @(posedge sys_clk);
        #2;
    endtask

    task automatic check(input string name, input int exp, input int act);
        n_checks++;
        assert (exp == act) else begin
            $display("Error %s/%s: expected %0d, actual %0d", test_name, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test();
        $display("test %s finished with %0d error(s)", test_name, test_errs);
        total_errs += test_errs;
        test_errs = 0;
    endtask

    task automatic randomize_channels();
        for (int i = 0; i < NCH; i++) begin
            ch_y[3'(i)] = 16'($random(seed));
            gain[3'(i)] = $random(seed);
        end
    endtask

    // one classic cycle, ack expected on the next edge
    task automatic bus_access(input logic we, input logic [12:0] adr,
                              input logic [15:0] dat, output logic [15:0] rdat);
        int waited;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat = dat;
        rdat   = '0;
        waited = 1;
        step(1);
        while (!wb_ack && waited < 10) begin
            step(1);
            waited++;
        end
        assert (wb_ack) else begin
            $display("bus access to address %0h got no ack within 10 cycles", adr);
            test_errs++;
        end
        if (wb_ack) begin
            check("ack latency", 1, waited);
            rdat = wb_rdat;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // stb low here, so the ack must be gone
        step(1);
        assert (!wb_ack) else begin
            $display("bus access to address %0h held ack for a second cycle", adr);
            test_errs++;
        end
    endtask

    task automatic run_capture(input logic [2:0] sel);
        logic [15:0] rd;
        int          polls;
        bus_access(1'b1, uberclock_pkg::REG_CTRL, {12'd0, sel, 1'b1}, rd);
        bus_access(1'b0, uberclock_pkg::REG_STATUS, 16'd0, rd);
        check($sformatf("capture sel %0d running", sel), 2, int'(rd));
        for (int i = 0; i < CAP_DEPTH; i++) begin
            randomize_channels();
            // gained value settles before the strobe
            step(2);
            sample_ce = 1'b1;
            cap_exp[i] = (sel < 3'd5) ? model_gain(ch_y[sel], gain[sel]) : 16'sd0;
            step(1);
            sample_ce = 1'b0;
        end
        polls = 0;
        rd = '0;
        while (!rd[0] && polls < 20) begin
            bus_access(1'b0, uberclock_pkg::REG_STATUS, 16'd0, rd);
            polls++;
        end
        assert (rd[0]) else begin
            $display("capture with sel %0d never reported done", sel);
            test_errs++;
        end
        check($sformatf("capture sel %0d done", sel), 1, int'(rd));
        for (int i = 0; i < CAP_DEPTH; i++) begin
            bus_access(1'b0, 13'h1000 | 13'(i), 16'd0, rd);
            check($sformatf("capture sel %0d word %0d", sel, i),
                  {16'd0, cap_exp[i]}, {16'd0, rd});
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [15:0] rd;
        logic [13:0] t;
        seed = 23;
        n_checks = 0;
        test_errs = 0;
        total_errs = 0;
        rst = 1'b1;
        ch_y = '0;
        gain = '0;
        final_shift = '0;
        adc0 = '0;
        adc1 = '0;
        dac1_sel = '0;
        dac2_sel = '0;
        sample_ce = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        step(5);
        rst = 1'b0;

        // idle status, dacs at midscale
        test_name = "reset_state";
        bus_access(1'b0, uberclock_pkg::REG_STATUS, 16'd0, rd);
        check("reset status", 0, int'(rd));
        dac1_sel = 4'd0;
        dac2_sel = 4'd1;
        step(8);
        check("reset dac1", 8192, int'(dac1_data));
        check("reset dac2", 8192, int'(dac2_data));
        finish_test();

        test_name = "gain_path";
        for (int k = 0; k < NCH; k++) begin
            randomize_channels();
            dac1_sel = 4'(k);
            dac2_sel = 4'((k + 1) % NCH);
            step(8);
            check($sformatf("gain%0d dac1", k), int'(dac_expect(dac1_sel)), int'(dac1_data));
            check($sformatf("gain%0d dac2", k), int'(dac_expect(dac2_sel)), int'(dac2_data));
        end
        finish_test();

        test_name = "sum_shift";
        for (int sh = 0; sh < 8; sh++) begin
            randomize_channels();
            final_shift = 3'(sh);
            dac1_sel = 4'd15;
            // codes 5 to 10, then 13 and 14
            dac2_sel = (sh < 6) ? 4'(5 + sh) : 4'(7 + sh);
            step(8);
            t = sum_top(model_sum());
            t = t << sh;
            check($sformatf("sum_out shift %0d", sh), int'(t), int'(sum_out));
            check($sformatf("sum dac1 shift %0d", sh), int'(dac_expect(dac1_sel)),
                  int'(dac1_data));
            check($sformatf("sum dac2 code %0d", dac2_sel), int'(dac_expect(dac2_sel)),
                  int'(dac2_data));
        end
        finish_test();

        test_name = "adc_path";
        dac1_sel = 4'd11;
        dac2_sel = 4'd12;
        for (int i = 0; i < 4; i++) begin
            adc0 = 12'($random(seed));
            adc1 = 12'($random(seed));
            step(8);
            check($sformatf("adc0 round %0d", i), int'(dac_expect(dac1_sel)), int'(dac1_data));
            check($sformatf("adc1 round %0d", i), int'(dac_expect(dac2_sel)), int'(dac2_data));
        end
        finish_test();

        test_name = "capture";
        run_capture(3'({$random(seed)} % NCH));
        // out of range select stores zeros
        run_capture(3'd5);
        finish_test();

        // unmapped read, ignored status write, ctrl write without arm
        test_name = "bus_protocol";
        bus_access(1'b0, 13'h0123, 16'd0, rd);
        check("unmapped read", 0, int'(rd));
        bus_access(1'b1, uberclock_pkg::REG_STATUS, 16'hffff, rd);
        bus_access(1'b1, uberclock_pkg::REG_CTRL, 16'h0004, rd);
        bus_access(1'b0, uberclock_pkg::REG_STATUS, 16'd0, rd);
        check("status after ctrl write without arm", 1, int'(rd));
        finish_test();

        total_errs += int'(i_uberclock.u_wb_capture_port.i_wb_sva.fails);
        $display("checks: %0d, errors: %0d", n_checks, total_errs);
        if (total_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== test/uberclock_sva.sv ====
`timescale 1ns/1ns

module uberclock_sva (
    input logic sys_clk,
    input logic rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic o_wb_ack
);
    // number of failed assertions
    int unsigned fails = 0;

    // ack is a single cycle pulse
    ack_one_cycle: assert property (@(posedge sys_clk) disable iff (rst)
        o_wb_ack |=> !o_wb_ack)
        else begin
            $error("wishbone ack high for two cycles in a row");
            fails++;
        end

    // ack only answers a request seen on the previous edge
    ack_after_req: assert property (@(posedge sys_clk) disable iff (rst)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
        else begin
            $error("wishbone ack without cyc and stb on the previous cycle");
            fails++;
        end

    ack_in_reset: assert property (@(posedge sys_clk) rst |-> !o_wb_ack)
        else begin
            $error("wishbone ack high during reset");
            fails++;
        end

endmodule

bind wb_capture_port uberclock_sva i_wb_sva (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .o_wb_ack (o_wb_ack)
);

// ==== rtl/uberclock.sv ====
`timescale 1ns/1ns

module uberclock #(
    parameter int CAP_DEPTH = 2048
) (
    input  logic                                              sys_clk,
    input  logic                                              rst,
    // channel samples and gains
    input  uberclock_pkg::sample_t [uberclock_pkg::NUM_CH-1:0] i_ch_y,
    input  logic [uberclock_pkg::NUM_CH-1:0][uberclock_pkg::GAIN_W-1:0] i_gain,
    input  logic [2:0]                                        i_final_shift,
    // raw adc words, offset binary
    input  logic [uberclock_pkg::ADC_W-1:0]                   i_adc0,
    input  logic [uberclock_pkg::ADC_W-1:0]                   i_adc1,
    input  logic [3:0]                                        i_dac1_sel,
    input  logic [3:0]                                        i_dac2_sel,
    input  logic                                              i_sample_ce,
    // wishbone slave
    input  logic                                              i_wb_cyc,
    input  logic                                              i_wb_stb,
    input  logic                                              i_wb_we,
    input  logic [uberclock_pkg::WB_ADR_W-1:0]                i_wb_adr,
    input  logic [uberclock_pkg::WB_DAT_W-1:0]                i_wb_dat,
    output uberclock_pkg::dac_word_t                          o_dac1_data,
    output uberclock_pkg::dac_word_t                          o_dac2_data,
    output uberclock_pkg::dac_word_t                          o_sum_out,
    output logic [uberclock_pkg::WB_DAT_W-1:0]                o_wb_dat,
    output logic                                              o_wb_ack
);
    uberclock_pkg::sample_t [uberclock_pkg::NUM_CH-1:0] gained;
    logic signed [uberclock_pkg::SUM_W-1:0]            sum_full;

    cap_if #(.CAP_DEPTH(CAP_DEPTH)) cap_bus ();

    // ------------------------------------------------------------------
    // signal path
    // ------------------------------------------------------------------
    channel_gain u_channel_gain (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .i_ch_y   (i_ch_y),
        .i_gain   (i_gain),
        .o_gained (gained)
    );

    sum_tree u_sum_tree (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .i_gained      (gained),
        .i_final_shift (i_final_shift),
        .o_sum_full    (sum_full),
        .o_sum_out     (o_sum_out)
    );

    dac_output_select u_dac_output_select (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .i_adc0      (i_adc0),
        .i_adc1      (i_adc1),
        .i_gained    (gained),
        .i_sum_full  (sum_full),
        .i_dac1_sel  (i_dac1_sel),
        .i_dac2_sel  (i_dac2_sel),
        .o_dac1_data (o_dac1_data),
        .o_dac2_data (o_dac2_data)
    );

    // ------------------------------------------------------------------
    // capture and its bus port
    // ------------------------------------------------------------------
    capture_buffer #(.CAP_DEPTH(CAP_DEPTH)) u_capture_buffer (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .i_gained    (gained),
        .i_sample_ce (i_sample_ce),
        .cap         (cap_bus.buffer)
    );

    wb_capture_port #(.CAP_DEPTH(CAP_DEPTH)) u_wb_capture_port (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .cap      (cap_bus.bus)
    );

endmodule

// ==== rtl/wb_capture_port.sv ====
`timescale 1ns/1ns

module wb_capture_port #(
    parameter int CAP_DEPTH = 2048
) (
    input  logic                                 sys_clk,
    input  logic                                 rst,
    input  logic                                 i_wb_cyc,
    input  logic                                 i_wb_stb,
    input  logic                                 i_wb_we,
    input  logic [uberclock_pkg::WB_ADR_W-1:0]   i_wb_adr,
    input  logic [uberclock_pkg::WB_DAT_W-1:0]   i_wb_dat,
    output logic [uberclock_pkg::WB_DAT_W-1:0]   o_wb_dat,
    output logic                                 o_wb_ack,
    cap_if.bus                                   cap
);
    localparam int AW = $clog2(CAP_DEPTH);
    localparam int DW = uberclock_pkg::WB_DAT_W;

    logic                  req;
    logic                  mem_hit;
    logic                  ctrl_wr;
    logic [2:0]            dbg_sel_q;
    logic                  arm_q;
    logic [DW-1:0]         rd_word;

    // new request only while no ack is out
    assign req     = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign mem_hit = i_wb_adr[uberclock_pkg::MEM_BASE_BIT];
    assign ctrl_wr = req && i_wb_we && !mem_hit && (i_wb_adr == uberclock_pkg::REG_CTRL);

    // read mux
    always_comb begin
        if (mem_hit) begin
            rd_word = cap.rd_data;
        end else if (i_wb_adr == uberclock_pkg::REG_STATUS) begin
            rd_word = {{(DW-2){1'b0}},
                       cap.state == uberclock_pkg::CAP_RUN,
                       cap.state == uberclock_pkg::CAP_DONE};
        end else if (i_wb_adr == uberclock_pkg::REG_CTRL) begin
            rd_word = {{(DW-4){1'b0}}, dbg_sel_q, 1'b0};
        end else begin
            rd_word = '0;
        end
    end

    // ------------------------------------------------------------------
    // ack, control register and arm pulse
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_wb_ack  <= 1'b0;
            dbg_sel_q <= '0;
            arm_q     <= 1'b0;
        end else begin
            o_wb_ack <= req;
            arm_q    <= ctrl_wr && i_wb_dat[0];
            if (ctrl_wr) begin
                dbg_sel_q <= i_wb_dat[3:1];
            end
        end
    end

    // read data lines up with the ack
    always_ff @(posedge sys_clk) begin
        if (req && !i_wb_we) begin
            o_wb_dat <= rd_word;
        end
    end

    assign cap.arm     = arm_q;
    assign cap.dbg_sel = dbg_sel_q;
    assign cap.rd_addr = i_wb_adr[AW-1:0];

endmodule

// ==== rtl/capture_buffer.sv ====
`timescale 1ns/1ns

module capture_buffer #(
    parameter int CAP_DEPTH = 2048
) (
    input  logic                                              sys_clk,
    input  logic                                              rst,
    input  uberclock_pkg::sample_t [uberclock_pkg::NUM_CH-1:0] i_gained,
    input  logic                                              i_sample_ce,
    cap_if.buffer                                             cap
);
    localparam int AW = $clog2(CAP_DEPTH);

    uberclock_pkg::sample_t mem [CAP_DEPTH];
    logic [AW-1:0]          wr_ptr;
    logic                   wr_en;
    uberclock_pkg::sample_t sel_sample;

    // debug channel select, out of range gives zeros
    always_comb begin
        if (cap.dbg_sel < 3'(uberclock_pkg::NUM_CH)) begin
            sel_sample = i_gained[cap.dbg_sel];
        end else begin
            sel_sample = '0;
        end
    end

    assign wr_en = (cap.state == uberclock_pkg::CAP_RUN) && i_sample_ce;

    // ------------------------------------------------------------------
    // capture fsm
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            cap.state <= uberclock_pkg::CAP_IDLE;
            wr_ptr    <= '0;
        end else if (cap.arm) begin
            // rearm from any state
            cap.state <= uberclock_pkg::CAP_RUN;
            wr_ptr    <= '0;
        end else if (wr_en) begin
            if (wr_ptr == AW'(CAP_DEPTH - 1)) begin
                cap.state <= uberclock_pkg::CAP_DONE;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // sample memory
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= sel_sample;
        end
    end

    // async read for the bus side
    assign cap.rd_data = mem[cap.rd_addr];

endmodule

// ==== rtl/dac_output_select.sv ====
`timescale 1ns/1ns

module dac_output_select (
    input  logic                                              sys_clk,
    input  logic                                              rst,
    input  logic [uberclock_pkg::ADC_W-1:0]                   i_adc0,
    input  logic [uberclock_pkg::ADC_W-1:0]                   i_adc1,
    input  uberclock_pkg::sample_t [uberclock_pkg::NUM_CH-1:0] i_gained,
    input  logic signed [uberclock_pkg::SUM_W-1:0]            i_sum_full,
    input  logic [3:0]                                        i_dac1_sel,
    input  logic [3:0]                                        i_dac2_sel,
    output uberclock_pkg::dac_word_t                          o_dac1_data,
    output uberclock_pkg::dac_word_t                          o_dac2_data
);
    localparam int MSB = uberclock_pkg::ADC_W - 1;
    localparam int SUM_LSB = uberclock_pkg::SUM_W - uberclock_pkg::DAC_W;

    // adc words in two's complement
    logic [uberclock_pkg::ADC_W-1:0] adc0_c;
    logic [uberclock_pkg::ADC_W-1:0] adc1_c;

    // offset binary in, flip the msb
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            adc0_c <= '0;
            adc1_c <= '0;
        end else begin
            adc0_c <= {~i_adc0[MSB], i_adc0[MSB-1:0]};
            adc1_c <= {~i_adc1[MSB], i_adc1[MSB-1:0]};
        end
    end

    // ------------------------------------------------------------------
    // source mux, shared by both dacs
    // ------------------------------------------------------------------
    function automatic uberclock_pkg::dac_word_t pick(input logic [3:0] sel);
        uberclock_pkg::dac_word_t word;
        case (uberclock_pkg::dac_src_e'(sel))
            uberclock_pkg::SRC_GAIN0, uberclock_pkg::SRC_GAIN1,
            uberclock_pkg::SRC_GAIN2, uberclock_pkg::SRC_GAIN3,
            uberclock_pkg::SRC_GAIN4: word = i_gained[sel[2:0]][15:2];
            // 12 bit adc word up into the 14 bit range
            uberclock_pkg::SRC_ADC0:  word = {adc0_c, 2'b00};
            uberclock_pkg::SRC_ADC1:  word = {adc1_c, 2'b00};
            default:                  word = i_sum_full[uberclock_pkg::SUM_W-1:SUM_LSB];
        endcase
        return word;
    endfunction

    // add midscale, wraps mod 2^14
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_dac1_data <= '0;
            o_dac2_data <= '0;
        end else begin
            o_dac1_data <= pick(i_dac1_sel) + uberclock_pkg::DAC_W'(uberclock_pkg::DAC_OFFSET);
            o_dac2_data <= pick(i_dac2_sel) + uberclock_pkg::DAC_W'(uberclock_pkg::DAC_OFFSET);
        end
    end

endmodule

// ==== rtl/sum_tree.sv ====
`timescale 1ns/1ns

module sum_tree (
    input  logic                                              sys_clk,
    input  logic                                              rst,
    input  uberclock_pkg::sample_t [uberclock_pkg::NUM_CH-1:0] i_gained,
    input  logic [2:0]                                        i_final_shift,
    output logic signed [uberclock_pkg::SUM_W-1:0]            o_sum_full,
    output uberclock_pkg::dac_word_t                          o_sum_out
);
    localparam int W1 = uberclock_pkg::SAMPLE_W + 1;
    localparam int W2 = uberclock_pkg::SAMPLE_W + 2;
    // top 14 bits of the 19 bit sum
    localparam int TRUNC_LSB = uberclock_pkg::SUM_W - uberclock_pkg::DAC_W;

    // level 1 pairs, channel 4 rides along
    logic signed [W1-1:0] l1_a;
    logic signed [W1-1:0] l1_b;
    logic signed [W1-1:0] l1_d;
    // level 2
    logic signed [W2-1:0] l2_s;
    logic signed [W2-1:0] l2_d;
    // truncated sum before the final shift
    uberclock_pkg::dac_word_t trunc_q;

    // ------------------------------------------------------------------
    // adder pipeline
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            l1_a       <= '0;
            l1_b       <= '0;
            l1_d       <= '0;
            l2_s       <= '0;
            l2_d       <= '0;
            o_sum_full <= '0;
            trunc_q    <= '0;
        end else begin
            l1_a       <= $signed(i_gained[0]) + $signed(i_gained[1]);
            l1_b       <= $signed(i_gained[2]) + $signed(i_gained[3]);
            l1_d       <= $signed(i_gained[4]);
            l2_s       <= l1_a + l1_b;
            l2_d       <= l1_d;
            o_sum_full <= l2_s + l2_d;
            // drop the 5 lsbs, no rounding
            trunc_q    <= o_sum_full[uberclock_pkg::SUM_W-1:TRUNC_LSB];
        end
    end

    // shift of 0 leaves the word as is, overflow bits fall off
    assign o_sum_out = trunc_q << i_final_shift;

endmodule

// ==== rtl/channel_gain.sv ====
`timescale 1ns/1ns

module channel_gain (
    input  logic                                              sys_clk,
    input  logic                                              rst,
    input  uberclock_pkg::sample_t [uberclock_pkg::NUM_CH-1:0] i_ch_y,
    input  logic [uberclock_pkg::NUM_CH-1:0][uberclock_pkg::GAIN_W-1:0] i_gain,
    output uberclock_pkg::sample_t [uberclock_pkg::NUM_CH-1:0] o_gained
);
    // 16 bit sample times 33 bit zero-extended gain
    localparam int PROD_W = uberclock_pkg::SAMPLE_W + uberclock_pkg::GAIN_W + 1;

    logic signed [PROD_W-1:0]  prod   [uberclock_pkg::NUM_CH];
    uberclock_pkg::sample_t    gain_d [uberclock_pkg::NUM_CH];

    always_comb begin
        for (int i = 0; i < uberclock_pkg::NUM_CH; i++) begin
            // gain is unsigned, so force a zero sign bit
            prod[i]   = $signed(i_ch_y[i]) * $signed({1'b0, i_gain[i]});
            // arithmetic shift then keep the low 16 bits
            gain_d[i] = uberclock_pkg::sample_t'(prod[i] >>> uberclock_pkg::GAIN_SHIFT);
        end
    end

    // all channels land in the same cycle
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_gained <= '0;
        end else begin
            for (int i = 0; i < uberclock_pkg::NUM_CH; i++) begin
                o_gained[i] <= gain_d[i];
            end
        end
    end

endmodule

// ==== rtl/cap_if.sv ====
`timescale 1ns/1ns

interface cap_if #(
    parameter int CAP_DEPTH = 2048
);
    localparam int AW = $clog2(CAP_DEPTH);

    // control from the bus side
    logic                       arm;
    logic [2:0]                 dbg_sel;
    logic [AW-1:0]              rd_addr;
    // status and readout from the buffer side
    uberclock_pkg::cap_state_e  state;
    uberclock_pkg::sample_t     rd_data;

    modport bus (
        output arm,
        output dbg_sel,
        output rd_addr,
        input  state,
        input  rd_data
    );

    // capture buffer side
    modport buffer (
        input  arm,
        input  dbg_sel,
        input  rd_addr,
        output state,
        output rd_data
    );

endinterface

// ==== rtl/uberclock_pkg.sv ====
package uberclock_pkg;

    // ------------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------------
    localparam int NUM_CH     = 5;
    localparam int SAMPLE_W   = 16;
    localparam int GAIN_W     = 32;
    // gain is fixed point with 30 fractional bits
    localparam int GAIN_SHIFT = 30;
    localparam int ADC_W      = 12;
    localparam int DAC_W      = 14;
    // midscale of the offset-binary dac
    localparam int DAC_OFFSET = 8192;
    localparam int SUM_W      = 19;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [DAC_W-1:0] dac_word_t;

    // dac source codes, anything not listed falls to the sum
    typedef enum logic [3:0] {
        SRC_GAIN0 = 4'd0,
        SRC_GAIN1 = 4'd1,
        SRC_GAIN2 = 4'd2,
        SRC_GAIN3 = 4'd3,
        SRC_GAIN4 = 4'd4,
        SRC_ADC0  = 4'd11,
        SRC_ADC1  = 4'd12,
        SRC_SUM   = 4'd15
    } dac_src_e;

    typedef enum logic [1:0] {
        CAP_IDLE = 2'd0,
        CAP_RUN  = 2'd1,
        CAP_DONE = 2'd2
    } cap_state_e;

    // ------------------------------------------------------------------
    // wishbone register map
    // ------------------------------------------------------------------
    localparam int WB_ADR_W = 13;
    localparam int WB_DAT_W = 16;
    localparam logic [WB_ADR_W-1:0] REG_CTRL   = 13'd0;
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 13'd1;
    // set means the access goes to the capture memory
    localparam int MEM_BASE_BIT = 12;

endpackage
